// File: hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Major opcodes, inst[6:0]
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_R_TYPE = 7'b0110011;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRL = 4'd7,
        ALU_SRA = 4'd8,
        ALU_BEQ = 4'd9,
        ALU_BNE = 4'd10,
        ALU_BGE = 4'd11,
        ALU_BLT = 4'd12,
        ALU_LUI = 4'd13
    } alu_op_t;

    // Same encoding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_t;

    typedef enum logic [1:0] {
        WB_PC_PLUS4 = 2'd0,
        WB_MEM      = 2'd1,
        WB_ALU      = 2'd2
    } wb_sel_t;

    typedef enum logic [1:0] {
        JMP_NONE   = 2'd0,
        JMP_BRANCH = 2'd1,
        JMP_JUMP   = 2'd2
    } jump_t;

endpackage

`default_nettype wire

// File: hdl/core_pipe_pkg.sv
`default_nettype none

package core_pipe_pkg;

    import rv_isa_pkg::*;

    // Decoded control word
    typedef struct packed {
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        logic      alu_src_a;   // pc instead of rs1
        logic      alu_src_b;   // imm instead of rs2
        wb_sel_t   wb_sel;
        jump_t     jump;
        logic      is_signed;
        mem_size_t size;
        alu_op_t   alu_op;
    } ctrl_t;

    // Decode to execute
    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
    } de_t;

    // Execute to result, alu_val doubles as memory address and jump target
    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] alu_val;
        logic [31:0] store_val;
        logic        taken;
    } ew_t;

endpackage

`default_nettype wire

// File: hdl/id_sign_extend.sv
`default_nettype none

module id_sign_extend (
    input  logic [31:0] inst,
    output logic [31:0] extend_imm
);
    import rv_isa_pkg::*;

    logic [6:0] opcode;

    assign opcode = inst[6:0];

    always_comb begin
        case (opcode)
            OP_IMM, OP_LOAD, OP_JALR: begin
                extend_imm = {{20{inst[31]}}, inst[31:20]};
            end
            OP_STORE: begin
                extend_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            OP_BRANCH: begin
                extend_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                              inst[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                extend_imm = {inst[31:12], 12'd0};
            end
            OP_JAL: begin
                extend_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                              inst[30:21], 1'b0};
            end
            default: begin
                extend_imm = 32'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/id_control.sv
`default_nettype none

module id_control (
    input  logic                 reset,
    input  logic [31:0]          inst,
    output core_pipe_pkg::ctrl_t ctrl,
    output logic [31:0]          imm
);
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        alt;
    logic        is_shift_imm;
    logic [31:0] extend_imm;

    // Shared by OP and OP-IMM, alt picks SUB or SRA
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt_op);
        case (f3)
            3'b000:         arith_op = alt_op ? ALU_SUB : ALU_ADD;
            3'b001:         arith_op = ALU_SLL;
            3'b010, 3'b011: arith_op = ALU_SLT;
            3'b100:         arith_op = ALU_XOR;
            3'b101:         arith_op = alt_op ? ALU_SRA : ALU_SRL;
            3'b110:         arith_op = ALU_OR;
            default:        arith_op = ALU_AND;
        endcase
    endfunction

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    id_sign_extend u_sign_extend (
        .inst       (inst),
        .extend_imm (extend_imm)
    );

    // SLLI, SRLI and SRAI take only the shift amount
    assign is_shift_imm = (opcode == OP_IMM) && (funct3[1:0] == 2'b01);
    assign imm          = is_shift_imm ? {27'd0, inst[24:20]} : extend_imm;

    always_comb begin
        ctrl = '0;
        if (!reset) begin
            case (opcode)
                OP_LUI: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src_b = 1'b1;
                    ctrl.alu_op    = ALU_LUI;
                    ctrl.wb_sel    = WB_ALU;
                end
                OP_AUIPC: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src_a = 1'b1;
                    ctrl.alu_src_b = 1'b1;
                    ctrl.wb_sel    = WB_ALU;
                end
                OP_JAL: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src_a = 1'b1;
                    ctrl.alu_src_b = 1'b1;
                    ctrl.jump      = JMP_JUMP;
                end
                OP_JALR: begin
                    if (funct3 == 3'b000) begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_src_b = 1'b1;
                        ctrl.jump      = JMP_JUMP;
                    end
                end
                OP_BRANCH: begin
                    // funct3 010 and 011 are not branches
                    if (funct3[2:1] != 2'b01) begin
                        ctrl.jump      = JMP_BRANCH;
                        ctrl.is_signed = !funct3[1];
                        ctrl.alu_op    = funct3[2] ? (funct3[0] ? ALU_BGE : ALU_BLT)
                                                   : (funct3[0] ? ALU_BNE : ALU_BEQ);
                    end
                end
                OP_LOAD: begin
                    if ((funct3[1:0] != 2'b11) && (funct3 != 3'b110)) begin
                        ctrl.mem_read  = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_src_b = 1'b1;
                        ctrl.wb_sel    = WB_MEM;
                        ctrl.size      = mem_size_t'(funct3[1:0]);
                        ctrl.is_signed = !funct3[2];
                    end
                end
                OP_STORE: begin
                    if (!funct3[2] && (funct3[1:0] != 2'b11)) begin
                        ctrl.mem_write = 1'b1;
                        ctrl.alu_src_b = 1'b1;
                        ctrl.size      = mem_size_t'(funct3[1:0]);
                    end
                end
                OP_IMM: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.alu_src_b = 1'b1;
                    ctrl.wb_sel    = WB_ALU;
                    ctrl.alu_op    = arith_op(funct3, alt && (funct3 == 3'b101));
                    ctrl.is_signed = (funct3 != 3'b011);
                end
                OP_R_TYPE: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = WB_ALU;
                    ctrl.alu_op    = arith_op(funct3, alt);
                    ctrl.is_signed = (funct3 != 3'b011);
                end
                default: begin
                    ctrl = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rs1_val,
    output logic [31:0] rs2_val,
    input  logic        we,
    input  logic [4:0]  rd,
    input  logic [31:0] wd
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= wd;
        end
    end

    // Write-first, a same-cycle write shows up on the read port
    assign rs1_val = (rs1 == 5'd0)          ? 32'd0 :
                     (we && (rd == rs1))    ? wd    : regs[rs1];
    assign rs2_val = (rs2 == 5'd0)          ? 32'd0 :
                     (we && (rd == rs2))    ? wd    : regs[rs2];

endmodule

`default_nettype wire

// File: hdl/ex_alu.sv
`default_nettype none

module ex_alu (
    input  core_pipe_pkg::de_t de,
    input  logic               fwd_we,
    input  logic [4:0]         fwd_rd,
    input  logic [31:0]        fwd_val,
    output core_pipe_pkg::ew_t ew
);
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    logic [31:0] rs1_fwd;
    logic [31:0] rs2_fwd;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] sum;
    logic [31:0] br_target;
    logic [31:0] alu_res;
    logic        slt;
    logic        lt;
    logic        cond;

    // Retiring item bypasses the stale register file value
    assign rs1_fwd = (fwd_we && (fwd_rd == de.rs1)) ? fwd_val : de.rs1_val;
    assign rs2_fwd = (fwd_we && (fwd_rd == de.rs2)) ? fwd_val : de.rs2_val;

    assign op_a = de.ctrl.alu_src_a ? de.pc  : rs1_fwd;
    assign op_b = de.ctrl.alu_src_b ? de.imm : rs2_fwd;

    assign sum       = op_a + op_b;
    assign br_target = de.pc + de.imm;

    assign slt = de.ctrl.is_signed ? ($signed(op_a) < $signed(op_b)) : (op_a < op_b);
    assign lt  = de.ctrl.is_signed ? ($signed(rs1_fwd) < $signed(rs2_fwd))
                                   : (rs1_fwd < rs2_fwd);

    always_comb begin
        case (de.ctrl.alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {31'd0, slt};
            ALU_SLL: alu_res = op_a << op_b[4:0];
            ALU_SRL: alu_res = op_a >> op_b[4:0];
            ALU_SRA: alu_res = $signed(op_a) >>> op_b[4:0];
            ALU_LUI: alu_res = op_b;
            default: alu_res = sum;
        endcase
    end

    always_comb begin
        case (de.ctrl.alu_op)
            ALU_BEQ: cond = (rs1_fwd == rs2_fwd);
            ALU_BNE: cond = (rs1_fwd != rs2_fwd);
            ALU_BLT: cond = lt;
            ALU_BGE: cond = !lt;
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        ew.ctrl      = de.ctrl;
        ew.pc        = de.pc;
        ew.rd        = de.rd;
        ew.store_val = rs2_fwd;
        case (de.ctrl.jump)
            JMP_BRANCH: begin
                ew.alu_val = br_target;
                ew.taken   = cond;
            end
            JMP_JUMP: begin
                // JALR is the rs1 based jump, its target drops bit 0
                ew.alu_val = {sum[31:1], sum[0] & de.ctrl.alu_src_a};
                ew.taken   = 1'b1;
            end
            default: begin
                ew.alu_val = alu_res;
                ew.taken   = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/wb_result.sv
`default_nettype none

module wb_result #(
    parameter int DMEM_WORDS = 256
) (
    input  logic               clk,
    input  logic               reset,
    input  core_pipe_pkg::ew_t ew_in,
    input  logic               ew_valid_in,
    input  core_pipe_pkg::ew_t ew,
    input  logic               ew_valid,
    output logic               retire_valid,
    output logic               retire_we,
    output logic [4:0]         retire_rd,
    output logic [31:0]        retire_data,
    output logic               redirect_valid,
    output logic [31:0]        redirect_pc
);
    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    logic [31:0]   dmem [DMEM_WORDS];
    logic [AW-1:0] mem_idx;
    logic [3:0]    lane_en;
    logic [31:0]   lane_data;
    logic [31:0]   rdata_q;
    logic [15:0]   half_val;
    logic [7:0]    byte_val;
    logic [31:0]   load_val;
    logic [31:0]   wb_val;

    // Word index wraps around the memory
    assign mem_idx = AW'(ew_in.alu_val[31:2] % DMEM_WORDS);

    always_comb begin
        case (ew_in.ctrl.size)
            BYTE: begin
                lane_en   = 4'b0001 << ew_in.alu_val[1:0];
                lane_data = {4{ew_in.store_val[7:0]}};
            end
            HALF: begin
                lane_en   = ew_in.alu_val[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{ew_in.store_val[15:0]}};
            end
            default: begin
                lane_en   = 4'b1111;
                lane_data = ew_in.store_val;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= 32'd0;
            end
        end else if (ew_valid_in && ew_in.ctrl.mem_write) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_en[b]) begin
                    dmem[mem_idx][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
    end

    // Whole word read here, lane picked a cycle later
    always_ff @(posedge clk) begin
        if (ew_valid_in && ew_in.ctrl.mem_read) begin
            rdata_q <= dmem[mem_idx];
        end
    end

    assign half_val = ew.alu_val[1] ? rdata_q[31:16] : rdata_q[15:0];
    assign byte_val = ew.alu_val[0] ? half_val[15:8] : half_val[7:0];

    always_comb begin
        case (ew.ctrl.size)
            BYTE:    load_val = {{24{ew.ctrl.is_signed & byte_val[7]}}, byte_val};
            HALF:    load_val = {{16{ew.ctrl.is_signed & half_val[15]}}, half_val};
            default: load_val = rdata_q;
        endcase
    end

    always_comb begin
        case (ew.ctrl.wb_sel)
            WB_PC_PLUS4: wb_val = ew.pc + 32'd4;
            WB_MEM:      wb_val = load_val;
            default:     wb_val = ew.alu_val;
        endcase
    end

    assign retire_valid   = ew_valid;
    assign retire_we      = ew_valid && ew.ctrl.reg_write && (ew.rd != 5'd0);
    assign retire_rd      = ew.rd;
    assign retire_data    = wb_val;
    assign redirect_valid = ew_valid && ew.taken;
    assign redirect_pc    = ew.alu_val;

endmodule

`default_nettype wire

// File: hdl/rv_exec_top.sv
`default_nettype none

module rv_exec_top #(
    parameter int DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    output logic        retire_valid,
    output logic        retire_we,
    output logic [4:0]  retire_rd,
    output logic [31:0] retire_data,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);
    import core_pipe_pkg::*;

    ctrl_t       id_ctrl;
    logic [31:0] id_imm;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    de_t         de_next;
    de_t         de_q;
    logic        de_valid;
    ew_t         ew_next;
    ew_t         ew_q;
    logic        ew_valid;

    id_control u_id_control (
        .reset (reset),
        .inst  (inst),
        .ctrl  (id_ctrl),
        .imm   (id_imm)
    );

    // Write port fed from the retiring item
    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs1     (inst[19:15]),
        .rs2     (inst[24:20]),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .we      (retire_we),
        .rd      (retire_rd),
        .wd      (retire_data)
    );

    assign de_next = '{ctrl: id_ctrl, pc: pc, imm: id_imm, rs1: inst[19:15],
                       rs2: inst[24:20], rd: inst[11:7], rs1_val: rs1_val,
                       rs2_val: rs2_val};

    always_ff @(posedge clk) begin
        if (reset) begin
            de_valid <= 1'b0;
            ew_valid <= 1'b0;
        end else begin
            de_valid <= inst_valid;
            ew_valid <= de_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            de_q <= de_next;
        end
        if (de_valid) begin
            ew_q <= ew_next;
        end
    end

    ex_alu u_ex_alu (
        .de      (de_q),
        .fwd_we  (retire_we),
        .fwd_rd  (retire_rd),
        .fwd_val (retire_data),
        .ew      (ew_next)
    );

    wb_result #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_wb_result (
        .clk            (clk),
        .reset          (reset),
        .ew_in          (ew_next),
        .ew_valid_in    (de_valid),
        .ew             (ew_q),
        .ew_valid       (ew_valid),
        .retire_valid   (retire_valid),
        .retire_we      (retire_we),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

`default_nettype wire

// File: sim/tb_rv_exec.sv
`default_nettype none

module tb_rv_exec;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;

    localparam int DMEM_WORDS = 256;
    localparam int N_ALU = 200;
    localparam int N_MEM = 150;
    localparam int N_BR  = 120;
    localparam int N_X0  = 60;
    localparam int TOTAL_ISSUE = 1 + N_ALU + N_MEM + N_BR + N_X0;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        redir;
        logic [31:0] rpc;
    } exp_t;

    logic        clk;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        retire_valid;
    logic        retire_we;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    integer      seed;
    int          errors;
    int          checks;
    int          tests;
    logic [31:0] cur_pc;
    logic [31:0] ref_regs [32];
    logic [31:0] ref_mem [DMEM_WORDS];
    exp_t        exp_q [$];

    rv_exec_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) dut0 (
        .clk            (clk),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .pc             (pc),
        .retire_valid   (retire_valid),
        .retire_we      (retire_we),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    always #50 clk = !clk;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %08h expected %08h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    function automatic logic [4:0] rreg();
        logic [31:0] r;
        r = rnd();
        return {1'b0, r[3:0]};
    endfunction

    // Reference ALU for OP and OP-IMM
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [31:0] x,
                                            input logic [31:0] y, input logic alt);
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << y[4:0];
            3'd2: return {31'd0, $signed(x) < $signed(y)};
            3'd3: return {31'd0, x < y};
            3'd4: return x ^ y;
            3'd5: return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    // Executes one instruction in program order and queues its retire record
    task automatic model_exec(input logic [31:0] w, input logic [31:0] ipc);
        exp_t        e;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] idx;
        logic        wr;
        logic [31:0] val;
        f3    = w[14:12];
        rd    = w[11:7];
        a     = ref_regs[w[19:15]];
        b     = ref_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {w[31:12], 12'd0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        e     = '0;
        wr    = 1'b0;
        val   = 32'd0;
        addr  = a + imm_i;
        idx   = (addr >> 2) % DMEM_WORDS;
        word  = ref_mem[idx];
        case (w[6:0])
            OP_LUI: begin
                wr  = 1'b1;
                val = imm_u;
            end
            OP_AUIPC: begin
                wr  = 1'b1;
                val = ipc + imm_u;
            end
            OP_JAL: begin
                wr      = 1'b1;
                val     = ipc + 32'd4;
                e.redir = 1'b1;
                e.rpc   = ipc + imm_j;
            end
            OP_JALR: begin
                if (f3 == 3'd0) begin
                    wr      = 1'b1;
                    val     = ipc + 32'd4;
                    e.redir = 1'b1;
                    e.rpc   = (a + imm_i) & ~32'd1;
                end
            end
            OP_BRANCH: begin
                e.rpc = ipc + imm_b;
                case (f3)
                    3'd0: e.redir = (a == b);
                    3'd1: e.redir = (a != b);
                    3'd4: e.redir = ($signed(a) < $signed(b));
                    3'd5: e.redir = ($signed(a) >= $signed(b));
                    3'd6: e.redir = (a < b);
                    3'd7: e.redir = (a >= b);
                    default: e.redir = 1'b0;
                endcase
            end
            OP_LOAD: begin
                wr = 1'b1;
                case (f3)
                    3'd0: val = {{24{word[8*addr[1:0]+7]}}, 8'(word >> (8*addr[1:0]))};
                    3'd1: val = {{16{word[16*addr[1]+15]}}, 16'(word >> (16*addr[1]))};
                    3'd2: val = word;
                    3'd4: val = {24'd0, 8'(word >> (8*addr[1:0]))};
                    3'd5: val = {16'd0, 16'(word >> (16*addr[1]))};
                    default: wr = 1'b0;
                endcase
            end
            OP_STORE: begin
                addr = a + imm_s;
                idx  = (addr >> 2) % DMEM_WORDS;
                case (f3)
                    3'd0: ref_mem[idx][8*addr[1:0] +: 8] = b[7:0];
                    3'd1: ref_mem[idx][16*addr[1] +: 16] = b[15:0];
                    3'd2: ref_mem[idx] = b;
                    default: ;
                endcase
            end
            OP_IMM: begin
                wr  = 1'b1;
                val = alu_ref(f3, a, imm_i, (f3 == 3'd5) && w[30]);
            end
            OP_R_TYPE: begin
                wr  = 1'b1;
                val = alu_ref(f3, a, b, w[30]);
            end
            default: ;
        endcase
        e.we   = wr && (rd != 5'd0);
        e.rd   = rd;
        e.data = val;
        if (e.we) begin
            ref_regs[rd] = val;
        end
        exp_q.push_back(e);
    endtask

    task automatic issue(input logic [31:0] w);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= w;
        pc         <= cur_pc;
        model_exec(w, cur_pc);
        cur_pc = cur_pc + 32'd4;
    endtask

    task automatic idle();
        @(posedge clk);
        inst_valid <= 1'b0;
    endtask

    // Random OP, OP-IMM, LUI or AUIPC word
    function automatic logic [31:0] gen_alu(input logic [4:0] rd);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] imm;
        r   = rnd();
        f3  = r[6:4];
        imm = r[27:16];
        case (r[1:0])
            2'd0: return {1'b0, r[8] && (f3 == 3'd0 || f3 == 3'd5), 5'd0, rreg(), rreg(),
                          f3, rd, OP_R_TYPE};
            2'd1: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    imm = {1'b0, r[9] && (f3 == 3'd5), 5'd0, r[20:16]};
                end
                return {imm, rreg(), f3, rd, OP_IMM};
            end
            2'd2: return {rnd() & 32'hffff_f000} | {20'd0, rd, OP_LUI};
            default: return {r[31:12], rd, OP_AUIPC};
        endcase
    endfunction

    function automatic logic [31:0] gen_mem(inout logic [7:0] last_word);
        logic [31:0] r;
        logic [11:0] off;
        logic [2:0]  f3;
        r = rnd();
        if (r[9:8] != 2'd0) begin
            last_word = r[23:16];
        end
        f3 = r[2] ? {1'b0, (r[1:0] == 2'd3) ? 2'd2 : r[1:0]} : r[6:4];
        if (f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7) begin
            f3 = 3'd2;
        end
        case (f3[1:0])
            2'd0:    off = {2'd0, last_word, r[11:10]};
            2'd1:    off = {2'd0, last_word, r[11], 1'b0};
            default: off = {2'd0, last_word, 2'd0};
        endcase
        if (r[2]) begin
            return {off[11:5], rreg(), 5'd0, f3, off[4:0], OP_STORE};
        end
        return {off, 5'd0, f3, rreg(), OP_LOAD};
    endfunction

    function automatic logic [31:0] gen_branch();
        logic [31:0] r;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        r   = rnd();
        rs1 = rreg();
        rs2 = r[3] ? rs1 : rreg();
        f3  = r[6:4];
        if (f3 == 3'd2 || f3 == 3'd3) begin
            f3 = 3'd0;
        end
        case (r[1:0])
            2'd0: return {r[31:12], rreg(), OP_JAL};
            2'd1: return {r[31:20], rs1, 3'd0, rreg(), OP_JALR};
            default: return {r[31], r[29:24], rs2, rs1, f3, r[11:8], r[30], OP_BRANCH};
        endcase
    endfunction

    task automatic drain();
        int n;
        n = 0;
        idle();
        while (exp_q.size() != 0 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected retires never arrived", exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        $display("test %s: %s", name, (errors == err_before) ? "ok" : "errors");
    endtask

    // Retire monitor
    always @(negedge clk) begin
        exp_t e;
        if (!reset && retire_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("retire reported with no instruction outstanding at %0t", $time);
            end else begin
                e = exp_q.pop_front();
                compare("retire_we", {31'd0, retire_we}, {31'd0, e.we});
                if (e.we) begin
                    compare("retire_rd", {27'd0, retire_rd}, {27'd0, e.rd});
                    compare("retire_data", retire_data, e.data);
                end
                compare("redirect_valid", {31'd0, redirect_valid}, {31'd0, e.redir});
                if (e.redir) begin
                    compare("redirect_pc", redirect_pc, e.rpc);
                end
            end
        end else if (!reset && redirect_valid) begin
            errors++;
            $display("redirect reported without a retire at %0t", $time);
        end
    end

    initial begin
        #((TOTAL_ISSUE + 20) * 100 * 2);
        $display("watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int          e0;
        logic [7:0]  last_word;
        logic [31:0] r;
        clk        = 1'b0;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = 32'd0;
        pc         = 32'd0;
        seed       = 32'h7f5f;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        cur_pc     = 32'h0000_1000;
        last_word  = 8'd0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = 32'd0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            ref_mem[i] = 32'd0;
        end

        e0 = errors;
        repeat (5) begin
            @(negedge clk);
            compare("retire_valid", {31'd0, retire_valid}, 32'd0);
            compare("retire_we", {31'd0, retire_we}, 32'd0);
            compare("redirect_valid", {31'd0, redirect_valid}, 32'd0);
        end
        @(posedge clk);
        reset <= 1'b0;
        repeat (10) begin
            @(negedge clk);
            compare("retire_valid", {31'd0, retire_valid}, 32'd0);
            compare("retire_we", {31'd0, retire_we}, 32'd0);
            compare("redirect_valid", {31'd0, redirect_valid}, 32'd0);
        end
        issue({12'h123, 5'd0, 3'd0, 5'd1, OP_IMM});
        idle();
        @(negedge clk);
        compare("retire_valid", {31'd0, retire_valid}, 32'd0);
        @(negedge clk);
        compare("retire_valid", {31'd0, retire_valid}, 32'd1);
        drain();
        report("reset_and_latency", e0);

        e0 = errors;
        for (int i = 0; i < N_ALU; i++) begin
            r = rnd();
            issue(gen_alu({1'b0, r[3:0]}));
        end
        drain();
        report("alu_and_immediates", e0);

        e0 = errors;
        for (int i = 0; i < N_MEM; i++) begin
            r = rnd();
            if (r[1:0] == 2'd0) begin
                issue(gen_alu(rreg()));
            end else begin
                issue(gen_mem(last_word));
            end
        end
        drain();
        report("loads_and_stores", e0);

        e0 = errors;
        for (int i = 0; i < N_BR; i++) begin
            r = rnd();
            if (r[1:0] == 2'd0) begin
                issue(gen_alu(rreg()));
            end else begin
                issue(gen_branch());
            end
        end
        drain();
        report("branches_and_jumps", e0);

        e0 = errors;
        for (int i = 0; i < N_X0; i++) begin
            r = rnd();
            case (r[1:0])
                2'd0: issue(gen_alu(5'd0));
                2'd1: issue({r[31:7], r[8] ? 7'b1110011 : 7'b0001111});
                default: issue(gen_alu(rreg()));
            endcase
        end
        drain();
        report("x0_and_illegal", e0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hdl/rv_isa_pkg.sv
hdl/core_pipe_pkg.sv
hdl/id_sign_extend.sv
hdl/id_control.sv
hdl/reg_file.sv
hdl/ex_alu.sv
hdl/wb_result.sv
hdl/rv_exec_top.sv
sim/tb_rv_exec.sv

// File: Makefile
TOP := tb_rv_exec

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TB FAILED" sim.log; then exit 1; fi
	@grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
